// ==== src/ualink_pkg.sv ====
/*
 * shared definitions for the ualink command engine
 * stream and memory widths, command opcodes, beat struct and command word union
 */
package ualink_pkg;

   // stream geometry
   localparam int DATA_WIDTH  = 64;
   localparam int STRB_WIDTH  = DATA_WIDTH / 8;   // one strobe per byte
   localparam int TUSER_WIDTH = 32;

   // command memory
   localparam int RAM_ADDR_WIDTH = 8;             // 256 words deep
   localparam int PAYLOAD_BEATS  = 8;             // words moved per command

   // command opcodes, top 16 bits of the command word
   localparam logic [15:0] OPCODE_WRITE = 16'h0245;
   localparam logic [15:0] OPCODE_READ  = 16'h0145;

   // ingress buffering
   localparam int FIFO_DEPTH_BITS    = 4;         // 16 entries
   localparam int NEARLY_FULL_MARGIN = 2;         // free slots left when ready drops

   typedef logic [RAM_ADDR_WIDTH-1:0] ram_addr_t;

   // command word layout, msb first
   typedef struct packed {
      logic [15:0]                             opcode;
      ram_addr_t                               addr;     // first word of the burst
      logic [DATA_WIDTH-16-RAM_ADDR_WIDTH-1:0] reserved;
   } ualink_cmd_t;

   /*
    * one stream word seen two ways: plain payload data, or the
    * command fields when it sits in the command slot of a packet
    */
   typedef union packed {
      logic [DATA_WIDTH-1:0] raw;
      ualink_cmd_t           cmd;
   } ualink_word_u;

   // everything carried by one axi stream transfer
   typedef struct packed {
      ualink_word_u           tdata;
      logic [STRB_WIDTH-1:0]  tstrb;
      logic [TUSER_WIDTH-1:0] tuser;
      logic                   tlast;   // end of packet
   } axis_beat_t;

endpackage

// ==== src/ualink_ingress_fifo.sv ====
/*
 * ingress fifo, 16 entry circular buffer with fall-through output
 * nearly-full flag drives s_axis_tready
 */
`timescale 1ns/1ns

module ualink_ingress_fifo
   import ualink_pkg::*;
(
   input  logic       axi_aclk,
   input  logic       axi_resetn,

   // upstream stream
   input  axis_beat_t s_axis_beat,
   input  logic       s_axis_tvalid,
   output logic       s_axis_tready,

   // towards the command engine
   output axis_beat_t fifo_beat,
   output logic       fifo_valid,
   input  logic       fifo_pop
);

   typedef logic [FIFO_DEPTH_BITS-1:0] fifo_ptr_t;
   typedef logic [FIFO_DEPTH_BITS:0]   fifo_count_t;   // one extra bit to hold full

   axis_beat_t  buffer [1 << FIFO_DEPTH_BITS];
   fifo_ptr_t   wr_ptr;
   fifo_ptr_t   rd_ptr;
   fifo_count_t count;
   logic        push;
   logic        pop;

   assign push = s_axis_tvalid && s_axis_tready;
   assign pop  = fifo_pop && fifo_valid;   // an empty fifo ignores pop

   // drop ready early so beats already in flight still have room
   assign s_axis_tready =
      count < fifo_count_t'((1 << FIFO_DEPTH_BITS) - NEARLY_FULL_MARGIN);

   assign fifo_valid = count != '0;
   assign fifo_beat  = buffer[rd_ptr];     // head entry, no read latency

   // storage
   always_ff @(posedge axi_aclk) begin
      if (push) begin
         buffer[wr_ptr] <= s_axis_beat;
      end
   end

   // pointers and occupancy
   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + fifo_ptr_t'(1);   // wraps at depth
         end
         if (pop) begin
            rd_ptr <= rd_ptr + fifo_ptr_t'(1);
         end

         case ({push, pop})
            2'b10:   count <= count + fifo_count_t'(1);
            2'b01:   count <= count - fifo_count_t'(1);
            default: count <= count;             // idle, or push and pop together
         endcase
      end
   end

endmodule

// ==== src/ualink_cmd_ram.sv ====
/*
 * command memory, 256 x 64
 * one write port, one registered read port with read enable
 */
`timescale 1ns/1ns

module ualink_cmd_ram
   import ualink_pkg::*;
(
   input  logic                  axi_aclk,

   // write port
   input  logic                  wr_en,
   input  ram_addr_t             wr_addr,
   input  logic [DATA_WIDTH-1:0] wr_data,

   // read port
   input  logic                  rd_en,
   input  ram_addr_t             rd_addr,
   output logic [DATA_WIDTH-1:0] rd_data
);

   logic [DATA_WIDTH-1:0] mem [1 << RAM_ADDR_WIDTH];

   always_ff @(posedge axi_aclk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // output register holds its word until the next enabled read
   always_ff @(posedge axi_aclk) begin
      if (rd_en) begin
         rd_data <= mem[rd_addr];
      end
   end

endmodule

// ==== src/ualink_cmd_engine.sv ====
/*
 * ualink command engine, packet beat tracking and command decode
 * drives command memory writes and reads, swaps read data into the output stream
 */
`timescale 1ns/1ns

module ualink_cmd_engine
   import ualink_pkg::*;
(
   input  logic                  axi_aclk,
   input  logic                  axi_resetn,

   // from ingress fifo
   input  axis_beat_t            fifo_beat,
   input  logic                  fifo_valid,
   output logic                  fifo_pop,

   // outgoing stream
   output axis_beat_t            m_axis_beat,
   output logic                  m_axis_tvalid,
   input  logic                  m_axis_tready,

   // command memory
   output logic                  wr_en,
   output ram_addr_t             wr_addr,
   output logic [DATA_WIDTH-1:0] wr_data,
   output logic                  rd_en,
   output ram_addr_t             rd_addr,
   input  logic [DATA_WIDTH-1:0] rd_data
);

   typedef enum logic [2:0] {
      ST_HEADER,   // beat 0
      ST_CMD,      // beat 1, command word
      ST_WRITE,    // payload stored to memory
      ST_READ,     // payload replaced by memory data
      ST_PASS      // rest of packet untouched
   } state_t;

   typedef logic [$clog2(PAYLOAD_BEATS)-1:0] beat_cnt_t;

   state_t      state;
   beat_cnt_t   payload_cnt;    // payload beat index within the command
   ram_addr_t   cmd_addr;       // base address latched from the command word
   ram_addr_t   beat_off;
   ualink_cmd_t cmd_word;
   logic        xfer;
   logic        last_payload;
   logic        is_write;
   logic        is_read;

   // stream path is combinational, a pop is the m_axis transfer itself
   assign xfer          = fifo_valid && m_axis_tready;
   assign fifo_pop      = xfer;
   assign m_axis_tvalid = fifo_valid;

   // only meaningful while state is ST_CMD
   assign cmd_word = fifo_beat.tdata.cmd;
   assign is_write = cmd_word.opcode == OPCODE_WRITE;
   assign is_read  = cmd_word.opcode == OPCODE_READ;

   assign beat_off     = ram_addr_t'(payload_cnt);
   assign last_payload = payload_cnt == beat_cnt_t'(PAYLOAD_BEATS - 1);

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         state       <= ST_HEADER;
         payload_cnt <= '0;
      end else if (xfer) begin
         if (fifo_beat.tlast) begin
            // end of packet also cuts a short command off
            state       <= ST_HEADER;
            payload_cnt <= '0;
         end else begin
            case (state)
               ST_HEADER: begin
                  state <= ST_CMD;
               end
               ST_CMD: begin
                  payload_cnt <= '0;
                  if (is_write) begin
                     state <= ST_WRITE;
                  end else if (is_read) begin
                     state <= ST_READ;
                  end else begin
                     state <= ST_PASS;   // unknown opcode
                  end
               end
               ST_WRITE, ST_READ: begin
                  payload_cnt <= payload_cnt + beat_cnt_t'(1);
                  if (last_payload) begin
                     state <= ST_PASS;
                  end
               end
               default: begin
                  state <= state;        // wait for tlast
               end
            endcase
         end
      end
   end

   always_ff @(posedge axi_aclk) begin
      if (xfer && state == ST_CMD) begin
         cmd_addr <= cmd_word.addr;
      end
   end

   // write port, each payload beat lands at base plus its index
   assign wr_en   = xfer && state == ST_WRITE;
   assign wr_addr = cmd_addr + beat_off;   // wraps modulo memory depth
   assign wr_data = fifo_beat.tdata.raw;

   /*
    * read one word ahead: the command beat fetches the base word and
    * each read payload beat fetches the word for the beat after it
    */
   always_comb begin
      rd_en   = 1'b0;
      rd_addr = (state == ST_CMD) ? cmd_word.addr : cmd_addr + beat_off + ram_addr_t'(1);
      if (xfer && !fifo_beat.tlast) begin
         if (state == ST_CMD && is_read) begin
            rd_en = 1'b1;
         end else if (state == ST_READ && !last_payload) begin
            rd_en = 1'b1;
         end
      end
   end

   // outgoing beat, data swapped during read payload only
   always_comb begin
      m_axis_beat = fifo_beat;
      if (state == ST_READ) begin
         m_axis_beat.tdata.raw = rd_data;
      end
   end

endmodule

// ==== src/ualink_turbo64.sv ====
/*
 * ualink turbo64 top level
 * ingress fifo feeding the command engine, engine driving the command memory
 */
`timescale 1ns/1ns

module ualink_turbo64
   import ualink_pkg::*;
(
   input  logic       axi_aclk,
   input  logic       axi_resetn,

   // ingress stream
   input  axis_beat_t s_axis_beat,
   input  logic       s_axis_tvalid,
   output logic       s_axis_tready,

   // egress stream
   output axis_beat_t m_axis_beat,
   output logic       m_axis_tvalid,
   input  logic       m_axis_tready
);

   // fifo to engine
   axis_beat_t            fifo_beat;
   logic                  fifo_valid;
   logic                  fifo_pop;

   // engine to memory
   logic                  wr_en;
   ram_addr_t             wr_addr;
   logic [DATA_WIDTH-1:0] wr_data;
   logic                  rd_en;
   ram_addr_t             rd_addr;
   logic [DATA_WIDTH-1:0] rd_data;

   ualink_ingress_fifo u_fifo (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axis_beat   (s_axis_beat),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .fifo_beat     (fifo_beat),
      .fifo_valid    (fifo_valid),
      .fifo_pop      (fifo_pop)
   );

   ualink_cmd_engine u_engine (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .fifo_beat     (fifo_beat),
      .fifo_valid    (fifo_valid),
      .fifo_pop      (fifo_pop),
      .m_axis_beat   (m_axis_beat),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready),
      .wr_en         (wr_en),
      .wr_addr       (wr_addr),
      .wr_data       (wr_data),
      .rd_en         (rd_en),
      .rd_addr       (rd_addr),
      .rd_data       (rd_data)
   );

   ualink_cmd_ram u_ram (
      .axi_aclk (axi_aclk),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data),
      .rd_en    (rd_en),
      .rd_addr  (rd_addr),
      .rd_data  (rd_data)
   );

endmodule

// ==== verification/ualink_turbo64_checker.sv ====
/*
 * stream protocol assertions for the ualink turbo64 top, attached by bind
 */
`timescale 1ns/1ns

module ualink_turbo64_checker
   import ualink_pkg::*;
(
   input logic       axi_aclk,
   input logic       axi_resetn,
   input axis_beat_t m_axis_beat,
   input logic       m_axis_tvalid,
   input logic       m_axis_tready,
   input logic       fifo_pop,
   input logic       wr_en,
   input logic       rd_en
);

   logic [7:0] beat_idx;   // position of the current m_axis beat in its packet
   logic       wr_slot;
   logic       rd_slot;

   always_ff @(posedge axi_aclk) begin
      if (!axi_resetn) begin
         beat_idx <= '0;
      end else if (m_axis_tvalid && m_axis_tready) begin
         beat_idx <= m_axis_beat.tlast ? '0 : beat_idx + 8'd1;
      end
   end

   assign wr_slot = beat_idx >= 8'd2 && beat_idx <= 8'(PAYLOAD_BEATS + 1);   // payload beats
   assign rd_slot = beat_idx >= 8'd1 && beat_idx <= 8'(PAYLOAD_BEATS);       // fetch runs ahead

   // stalled beat holds until it transfers
   a_stall_stable: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      m_axis_tvalid && !m_axis_tready |=> m_axis_tvalid && $stable(m_axis_beat))
      else $error("m_axis beat changed or dropped while stalled");

   a_reset_idle: assert property (@(posedge axi_aclk)
      !axi_resetn |=> !m_axis_tvalid)   // no output right after reset
      else $error("m_axis_tvalid high in the cycle after reset");

   // memory access only on a forwarded beat inside the command window
   a_mem_on_pop: assert property (@(posedge axi_aclk) disable iff (!axi_resetn)
      (wr_en || rd_en) |-> fifo_pop && (!wr_en || wr_slot) && (!rd_en || rd_slot))
      else $error("memory access outside the command beats of a transfer");

endmodule

bind ualink_turbo64 ualink_turbo64_checker u_checker (
   .axi_aclk      (axi_aclk),
   .axi_resetn    (axi_resetn),
   .m_axis_beat   (m_axis_beat),
   .m_axis_tvalid (m_axis_tvalid),
   .m_axis_tready (m_axis_tready),
   .fifo_pop      (fifo_pop),
   .wr_en         (wr_en),
   .rd_en         (rd_en)
);

// ==== verification/ualink_turbo64_tb.sv ====
/*
 * testbench for the ualink turbo64 command engine
 * packet table, reference model, stream driver and monitor, watchdog
 */
`timescale 1ns/1ns

module ualink_turbo64_tb
   import ualink_pkg::*;
;

   localparam int NUM_ROWS       = 8;
   localparam int RESET_CYCLES   = 5;
   localparam int STALL_CYCLES   = 30;
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * NUM_ROWS * 200 + STALL_CYCLES;

   localparam int READY_ON     = 0;
   localparam int READY_RANDOM = 1;
   localparam int READY_HOLD   = 2;

   localparam int MODE_PASS  = 0;
   localparam int MODE_WRITE = 1;
   localparam int MODE_READ  = 2;

   typedef struct packed {
      logic [15:0]            opcode;
      ram_addr_t              addr;
      logic [7:0]             beats;    // beats in the whole packet
      logic [TUSER_WIDTH-1:0] tuser;
      logic [31:0]            seed;     // payload words derive from this
   } pkt_row_t;

   // packets in the order they are sent
   pkt_row_t rows [NUM_ROWS] = '{
      '{OPCODE_WRITE, 8'h10, 8'd12, 32'h0000_0A01, 32'h1357_9BDF},
      '{OPCODE_READ,  8'h10, 8'd11, 32'h0000_0A02, 32'h2468_ACE0},
      '{OPCODE_WRITE, 8'hFC, 8'd10, 32'h0000_0B01, 32'h0F1E_2D3C},
      '{OPCODE_READ,  8'hFC, 8'd10, 32'h0000_0B02, 32'h4B5A_6978},
      '{16'h0377,     8'h10, 8'd7,  32'h0000_0C01, 32'h8796_A5B4},
      '{OPCODE_READ,  8'h10, 8'd2,  32'h0000_0C02, 32'hC3D2_E1F0},  // tlast on command beat
      '{OPCODE_WRITE, 8'h40, 8'd10, 32'h0000_0D01, 32'h1122_3344},
      '{OPCODE_READ,  8'h40, 8'd14, 32'h0000_0D02, 32'h5566_7788}
   };

   string row_names [NUM_ROWS] = '{
      "write_a", "read_a", "write_wrap", "read_wrap",
      "other_opcode", "read_short", "write_b", "read_b"
   };

   logic       axi_aclk      = 1'b0;
   logic       axi_resetn    = 1'b0;
   axis_beat_t s_axis_beat   = '0;
   logic       s_axis_tvalid = 1'b0;
   logic       s_axis_tready;
   axis_beat_t m_axis_beat;
   logic       m_axis_tvalid;
   logic       m_axis_tready = 1'b1;

   int                    ready_mode = READY_ON;
   logic [DATA_WIDTH-1:0] model_mem [1 << RAM_ADDR_WIDTH];
   axis_beat_t            exp_q [$];    // expected output beats in arrival order
   string                 name_q [$];

   ualink_turbo64 UUT (
      .axi_aclk      (axi_aclk),
      .axi_resetn    (axi_resetn),
      .s_axis_beat   (s_axis_beat),
      .s_axis_tvalid (s_axis_tvalid),
      .s_axis_tready (s_axis_tready),
      .m_axis_beat   (m_axis_beat),
      .m_axis_tvalid (m_axis_tvalid),
      .m_axis_tready (m_axis_tready)
   );

   always #5 axi_aclk = ~axi_aclk;

   task automatic stop_with_failure();
      $display("RESULT: FAIL");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_beat(input string name, input axis_beat_t exp, input axis_beat_t act);
      if (act !== exp) begin
         $display("** Error %s: expected %h, actual %h", name, exp, act);
         stop_with_failure();
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("** Error %s: expected %b, actual %b", name, exp, act);
         stop_with_failure();
      end
   endtask

   function automatic logic [DATA_WIDTH-1:0] data_word(input logic [31:0] seed, input int idx);
      return {seed + 32'(idx), ~seed ^ (32'(idx) << 8)};
   endfunction

   // starts 1 ns after a rising edge and holds the beat until the fifo takes it
   task automatic send_beat(input axis_beat_t beat);
      logic took;
      took          = 1'b0;
      s_axis_beat   = beat;
      s_axis_tvalid = 1'b1;
      while (!took) begin
         @(negedge axi_aclk);
         took = s_axis_tready;
         @(posedge axi_aclk);
         #1;
      end
      s_axis_tvalid = 1'b0;
   endtask

   // builds one packet, queues its expected output, sends it
   task automatic send_packet(input int idx, input int pass);
      pkt_row_t   row;
      axis_beat_t beat;
      axis_beat_t exp;
      ram_addr_t  waddr;
      int         nbeats;
      int         mode;
      row    = rows[idx];
      nbeats = int'(row.beats);
      mode   = MODE_PASS;
      for (int i = 0; i < nbeats; i++) begin
         beat.tdata.raw = data_word(row.seed, i);
         if (i == 1) begin
            beat.tdata.cmd = '{opcode: row.opcode, addr: row.addr, reserved: 40'(row.seed)};
         end
         beat.tstrb = (i == nbeats - 1) ? 8'h0F : 8'hFF;
         beat.tuser = row.tuser ^ 32'(i);
         beat.tlast = (i == nbeats - 1);
         exp        = beat;

         // payload slots are beats 2 to 9
         if (i >= 2 && i < 2 + PAYLOAD_BEATS) begin
            waddr = row.addr + ram_addr_t'(i - 2);   // wraps at 256
            if (mode == MODE_WRITE) begin
               model_mem[waddr] = beat.tdata.raw;
            end else if (mode == MODE_READ) begin
               exp.tdata.raw = model_mem[waddr];
            end
         end
         if (i == 1 && !beat.tlast) begin
            if (row.opcode == OPCODE_WRITE) begin
               mode = MODE_WRITE;
            end else if (row.opcode == OPCODE_READ) begin
               mode = MODE_READ;
            end
         end

         exp_q.push_back(exp);
         name_q.push_back($sformatf("%s pass %0d beat %0d", row_names[idx], pass, i));
         send_beat(beat);
      end
   endtask

   // waits for every expected beat, then checks the output goes idle
   task automatic wait_drain(input string name);
      while (exp_q.size() != 0) begin
         @(negedge axi_aclk);
      end
      repeat (3) @(negedge axi_aclk);
      check_flag(name, 1'b0, m_axis_tvalid);
   endtask

   // egress ready changes just after the clock edge
   always @(posedge axi_aclk) begin
      #1;
      case (ready_mode)
         READY_RANDOM: m_axis_tready = ($urandom % 3) != 0;
         READY_HOLD:   m_axis_tready = 1'b0;
         default:      m_axis_tready = 1'b1;
      endcase
   end

   // a beat seen here transfers at the next rising edge
   always @(negedge axi_aclk) begin : receive
      axis_beat_t exp_beat;
      string      beat_name;
      if (axi_resetn && m_axis_tvalid && m_axis_tready) begin
         if (exp_q.size() == 0) begin
            $display("output beat %h arrived with no beat outstanding", m_axis_beat);
            stop_with_failure();
         end else begin
            exp_beat  = exp_q.pop_front();
            beat_name = name_q.pop_front();
            check_beat(beat_name, exp_beat, m_axis_beat);
         end
      end
   end

   initial begin : watchdog
      repeat (TIMEOUT_CYCLES) @(posedge axi_aclk);
      $display("run timed out, not finished after %0d cycles", TIMEOUT_CYCLES);
      stop_with_failure();
   end

   initial begin : main
      int r;
      int k;
      void'($urandom(19));
      repeat (RESET_CYCLES) @(posedge axi_aclk);
      #1;
      axi_resetn = 1'b1;

      @(negedge axi_aclk);
      check_flag("reset_tvalid", 1'b0, m_axis_tvalid);
      check_flag("reset_tready", 1'b1, s_axis_tready);

      // first pass with egress always ready
      @(posedge axi_aclk);
      #1;
      for (r = 0; r < NUM_ROWS; r++) begin
         send_packet(r, 1);
      end
      wait_drain("drain_pass1");

      // second pass holds egress off first so the fifo fills
      ready_mode = READY_HOLD;
      @(posedge axi_aclk);
      #1;
      fork
         begin
            for (k = 0; k < NUM_ROWS; k++) begin
               send_packet(k, 2);
            end
         end
         begin
            repeat (STALL_CYCLES) @(negedge axi_aclk);
            check_flag("stall_tready", 1'b0, s_axis_tready);
            ready_mode = READY_RANDOM;
         end
      join
      wait_drain("drain_pass2");

      $display("RESULT: PASS");
      $finish;
   end

endmodule

// ==== verilog.f ====
src/ualink_pkg.sv
src/ualink_ingress_fifo.sv
src/ualink_cmd_ram.sv
src/ualink_cmd_engine.sv
src/ualink_turbo64.sv
verification/ualink_turbo64_checker.sv
verification/ualink_turbo64_tb.sv

// ==== Makefile ====
# Verilator build and run for the ualink turbo64 testbench

TOOL      := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := ualink_turbo64_tb
FILELIST  := verilog.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := RESULT: PASS

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the outcome, the simulator status alone is not used
run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
